//--- src/glay_setup_cfg.svh
`ifndef GLAY_SETUP_CFG_SVH
`define GLAY_SETUP_CFG_SVH

// Memory request widths
`define GLAY_ADDR_W      64
`define GLAY_COUNT_W     16
`define GLAY_ID_W        16
`define GLAY_LINE_BYTES  64

// Request FIFO sizing
`define GLAY_FIFO_DEPTH  16
`define GLAY_FIFO_AFULL  (`GLAY_FIFO_DEPTH - 2)

// Host register block
`define GLAY_AXIL_ADDR_W 6
`define GLAY_AXIL_DATA_W 32
`define GLAY_REG_CTRL    6'h00
`define GLAY_REG_STATUS  6'h04
`define GLAY_REG_ADDR_LO 6'h08
`define GLAY_REG_ADDR_HI 6'h0C
`define GLAY_REG_LINES   6'h10
`define GLAY_REG_STRIDE  6'h14

`endif

//--- src/glay_setup_pkg.sv
`default_nettype none

`include "glay_setup_cfg.svh"

package glay_setup_pkg;

    // Setup FSM states
    typedef enum logic [2:0] {
        SETUP_RESET,
        SETUP_IDLE,
        SETUP_REQ_START,
        SETUP_REQ_BUSY,
        SETUP_REQ_DONE
    } setup_state_t;

    // Kernel descriptor as programmed by the host
    typedef struct packed {
        logic [`GLAY_ADDR_W-1:0]  array_pointer;
        logic [`GLAY_COUNT_W-1:0] num_lines;
        logic [`GLAY_COUNT_W-1:0] stride;
    } setup_desc_t;

    typedef struct packed {
        logic        valid;
        setup_desc_t payload;
    } setup_desc_in_t;

    // One cache-line read request
    typedef struct packed {
        logic [`GLAY_ADDR_W-1:0] address;
        logic [`GLAY_ID_W-1:0]   id;
    } mem_req_t;

    // AXI4-Lite, master side fields
    typedef struct packed {
        logic                          awvalid;
        logic [`GLAY_AXIL_ADDR_W-1:0]  awaddr;
        logic                          wvalid;
        logic [`GLAY_AXIL_DATA_W-1:0]  wdata;
        logic [`GLAY_AXIL_DATA_W/8-1:0] wstrb;
        logic                          bready;
        logic                          arvalid;
        logic [`GLAY_AXIL_ADDR_W-1:0]  araddr;
        logic                          rready;
    } axil_req_t;

    // AXI4-Lite, slave side fields
    typedef struct packed {
        logic                         awready;
        logic                         wready;
        logic                         bvalid;
        logic [1:0]                   bresp;
        logic                         arready;
        logic                         rvalid;
        logic [`GLAY_AXIL_DATA_W-1:0] rdata;
        logic [1:0]                   rresp;
    } axil_rsp_t;

endpackage : glay_setup_pkg

`default_nettype wire

//--- src/glay_req_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "glay_setup_cfg.svh"

module glay_req_fifo import glay_setup_pkg::*; (
    input  logic     ap_clk,
    input  logic     setup_areset,
    input  logic     wr_en,
    input  mem_req_t din,
    output logic     full,
    output logic     almost_full,
    output logic     empty,
    input  logic     rd_en,
    output mem_req_t dout
);

    localparam int DEPTH = `GLAY_FIFO_DEPTH;
    localparam int AFULL = `GLAY_FIFO_AFULL;
    localparam int PTR_W = $clog2(DEPTH);

    mem_req_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign push = wr_en && !full;
    assign pop  = rd_en && !empty;

    assign full        = (count == (PTR_W+1)'(DEPTH));
    assign almost_full = (count >= (PTR_W+1)'(AFULL));
    assign empty       = (count == '0);

    // Head word shows through
    assign dout = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : glay_req_fifo

`default_nettype wire

//--- src/glay_serial_read_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "glay_setup_cfg.svh"

module glay_serial_read_engine import glay_setup_pkg::*; (
    input  logic        ap_clk,
    input  logic        setup_areset,
    input  logic        engine_start,
    input  setup_desc_t engine_desc,
    input  logic        engine_pause,
    output logic        engine_req_valid,
    output mem_req_t    engine_req,
    output logic        engine_done
);

    localparam int ADDR_W  = `GLAY_ADDR_W;
    localparam int COUNT_W = `GLAY_COUNT_W;
    localparam int ID_W    = `GLAY_ID_W;

    localparam logic [ADDR_W-1:0] LINE_BYTES = ADDR_W'(`GLAY_LINE_BYTES);

    logic               active;
    logic               issue;
    logic [COUNT_W-1:0] lines_left;
    logic [COUNT_W-1:0] line_index;
    logic [ADDR_W-1:0]  next_address;
    logic [ADDR_W-1:0]  address_step;

    // One request per cycle while lines remain and the FIFO has room
    assign issue = active && !engine_pause && (lines_left != '0);

// ----------------------------------------------------------------------
//   Line counter and control
// ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            active           <= 1'b0;
            lines_left       <= '0;
            engine_req_valid <= 1'b0;
            engine_done      <= 1'b0;
        end else if (engine_start) begin
            active           <= 1'b1;
            lines_left       <= engine_desc.num_lines;
            engine_req_valid <= 1'b0;
            engine_done      <= 1'b0;
        end else begin
            engine_req_valid <= issue;
            if (issue) begin
                lines_left <= lines_left - 1'b1;
            end
            // Last request already left the output register
            if (active && (lines_left == '0)) begin
                active      <= 1'b0;
                engine_done <= 1'b1;
            end
        end
    end

// ----------------------------------------------------------------------
//   Running address
// ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_start) begin
            next_address <= engine_desc.array_pointer;
            address_step <= ADDR_W'(engine_desc.stride) * LINE_BYTES;
            line_index   <= '0;
        end else if (issue) begin
            engine_req.address <= next_address;
            engine_req.id      <= ID_W'(line_index);
            next_address       <= next_address + address_step;
            line_index         <= line_index + 1'b1;
        end
    end

endmodule : glay_serial_read_engine

`default_nettype wire

//--- src/glay_setup_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "glay_setup_cfg.svh"

module glay_setup_regs import glay_setup_pkg::*; (
    input  logic           ap_clk,
    input  logic           setup_areset,
    input  axil_req_t      axil_req,
    output axil_rsp_t      axil_rsp,
    output setup_desc_in_t setup_desc,
    input  logic           setup_busy,
    input  logic           setup_done
);

    localparam int DATA_W = `GLAY_AXIL_DATA_W;

    logic              aw_w_ready;
    logic              b_valid;
    logic              ar_ready;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;

    logic [31:0] reg_addr_lo;
    logic [31:0] reg_addr_hi;
    logic [15:0] reg_lines;
    logic [15:0] reg_stride;
    logic        done_flag;
    logic        desc_valid;

    logic              wr_fire;
    logic              rd_fire;
    logic              start_ok;
    logic [DATA_W-1:0] wr_old;
    logic [DATA_W-1:0] wr_merged;
    logic [DATA_W-1:0] rd_word;

// ----------------------------------------------------------------------
//   Handshakes
// ----------------------------------------------------------------------
    assign wr_fire = aw_w_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = ar_ready && axil_req.arvalid;

    // Start only counts when the setup block can take it
    assign start_ok = wr_fire && (axil_req.awaddr == `GLAY_REG_CTRL)
                    && axil_req.wstrb[0] && axil_req.wdata[0]
                    && !setup_busy && !desc_valid;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            aw_w_ready <= 1'b0;
            b_valid    <= 1'b0;
            ar_ready   <= 1'b0;
            r_valid    <= 1'b0;
        end else begin
            aw_w_ready <= !aw_w_ready && !b_valid && axil_req.awvalid && axil_req.wvalid;
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (axil_req.bready) begin
                b_valid <= 1'b0;
            end
            ar_ready <= !ar_ready && !r_valid && axil_req.arvalid;
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (axil_req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

// ----------------------------------------------------------------------
//   Descriptor registers
// ----------------------------------------------------------------------
    always_comb begin
        case (axil_req.awaddr)
            `GLAY_REG_ADDR_LO: wr_old = reg_addr_lo;
            `GLAY_REG_ADDR_HI: wr_old = reg_addr_hi;
            `GLAY_REG_LINES:   wr_old = {16'h0, reg_lines};
            `GLAY_REG_STRIDE:  wr_old = {16'h0, reg_stride};
            default:           wr_old = '0;
        endcase
        // Byte lanes not strobed keep their old value
        for (int b = 0; b < DATA_W / 8; b++) begin
            wr_merged[8*b +: 8] = axil_req.wstrb[b] ? axil_req.wdata[8*b +: 8] : wr_old[8*b +: 8];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            reg_addr_lo <= '0;
            reg_addr_hi <= '0;
            reg_lines   <= '0;
            reg_stride  <= '0;
        end else if (wr_fire) begin
            case (axil_req.awaddr)
                `GLAY_REG_ADDR_LO: reg_addr_lo <= wr_merged;
                `GLAY_REG_ADDR_HI: reg_addr_hi <= wr_merged;
                `GLAY_REG_LINES:   reg_lines   <= wr_merged[15:0];
                `GLAY_REG_STRIDE:  reg_stride  <= wr_merged[15:0];
                default: ;
            endcase
        end
    end

    // Start pulse and sticky done
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            desc_valid <= 1'b0;
            done_flag  <= 1'b0;
        end else begin
            desc_valid <= start_ok;
            if (start_ok) begin
                done_flag <= 1'b0;
            end else if (setup_done) begin
                done_flag <= 1'b1;
            end
        end
    end

    assign setup_desc.valid                 = desc_valid;
    assign setup_desc.payload.array_pointer = {reg_addr_hi, reg_addr_lo};
    assign setup_desc.payload.num_lines     = reg_lines;
    assign setup_desc.payload.stride        = reg_stride;

// ----------------------------------------------------------------------
//   Read back
// ----------------------------------------------------------------------
    always_comb begin
        case (axil_req.araddr)
            `GLAY_REG_STATUS:  rd_word = {30'h0, done_flag, setup_busy | desc_valid};
            `GLAY_REG_ADDR_LO: rd_word = reg_addr_lo;
            `GLAY_REG_ADDR_HI: rd_word = reg_addr_hi;
            `GLAY_REG_LINES:   rd_word = {16'h0, reg_lines};
            `GLAY_REG_STRIDE:  rd_word = {16'h0, reg_stride};
            default:           rd_word = '0;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (rd_fire) begin
            r_data <= rd_word;
        end
    end

    assign axil_rsp.awready = aw_w_ready;
    assign axil_rsp.wready  = aw_w_ready;
    assign axil_rsp.bvalid  = b_valid;
    assign axil_rsp.bresp   = 2'b00;
    assign axil_rsp.arready = ar_ready;
    assign axil_rsp.rvalid  = r_valid;
    assign axil_rsp.rdata   = r_data;
    assign axil_rsp.rresp   = 2'b00;

endmodule : glay_setup_regs

`default_nettype wire

//--- src/glay_kernel_setup.sv
`timescale 1ns/10ps
`default_nettype none

module glay_kernel_setup import glay_setup_pkg::*; (
    input  logic           ap_clk,
    input  logic           setup_areset,
    input  setup_desc_in_t setup_desc,
    output logic           setup_busy,
    output logic           setup_done,
    output logic           req_valid,
    output mem_req_t       req,
    input  logic           req_ready
);

    setup_state_t   current_state;
    setup_state_t   next_state;
    setup_desc_in_t desc_reg;

    logic     engine_start;
    logic     engine_pause;
    logic     engine_req_valid;
    mem_req_t engine_req;
    logic     engine_done;

    logic     fifo_full;
    logic     fifo_almost_full;
    logic     fifo_empty;
    logic     fifo_rd_en;
    mem_req_t fifo_dout;

// ----------------------------------------------------------------------
//   Descriptor register
// ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            desc_reg.valid <= 1'b0;
        end else begin
            desc_reg.valid <= setup_desc.valid;
        end
    end

    // Payload held for the engine load two cycles later
    always_ff @(posedge ap_clk) begin
        if (setup_desc.valid) begin
            desc_reg.payload <= setup_desc.payload;
        end
    end

// ----------------------------------------------------------------------
//   Setup FSM
// ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            current_state <= SETUP_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            SETUP_RESET:     next_state = SETUP_IDLE;
            SETUP_IDLE: begin
                if (desc_reg.valid) begin
                    next_state = SETUP_REQ_START;
                end
            end
            SETUP_REQ_START: next_state = SETUP_REQ_BUSY;
            SETUP_REQ_BUSY: begin
                // Wait for the last request to leave the FIFO
                if (engine_done && fifo_empty) begin
                    next_state = SETUP_REQ_DONE;
                end
            end
            SETUP_REQ_DONE:  next_state = SETUP_IDLE;
            default:         next_state = SETUP_RESET;
        endcase
    end

    assign engine_start = (current_state == SETUP_REQ_START);
    assign setup_done   = (current_state == SETUP_REQ_DONE);
    assign setup_busy   = desc_reg.valid
                        || ((current_state != SETUP_IDLE) && (current_state != SETUP_RESET));

// ----------------------------------------------------------------------
//   Request generation and FIFO
// ----------------------------------------------------------------------
    assign engine_pause = fifo_almost_full || fifo_full;

    glay_serial_read_engine u_glay_serial_read_engine (
        .ap_clk           (ap_clk),
        .setup_areset     (setup_areset),
        .engine_start     (engine_start),
        .engine_desc      (desc_reg.payload),
        .engine_pause     (engine_pause),
        .engine_req_valid (engine_req_valid),
        .engine_req       (engine_req),
        .engine_done      (engine_done)
    );

    glay_req_fifo u_glay_req_fifo (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (engine_req_valid),
        .din          (engine_req),
        .full         (fifo_full),
        .almost_full  (fifo_almost_full),
        .empty        (fifo_empty),
        .rd_en        (fifo_rd_en),
        .dout         (fifo_dout)
    );

    // FIFO head drives the memory stream
    assign req_valid  = !fifo_empty;
    assign req        = fifo_dout;
    assign fifo_rd_en = req_valid && req_ready;

endmodule : glay_kernel_setup

`default_nettype wire

//--- src/glay_setup_top.sv
`timescale 1ns/10ps
`default_nettype none

module glay_setup_top import glay_setup_pkg::*; (
    input  logic      ap_clk,
    input  logic      setup_areset,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      req_valid,
    output mem_req_t  req,
    input  logic      req_ready
);

    // Between register block and setup block
    setup_desc_in_t setup_desc;
    logic           setup_busy;
    logic           setup_done;

    glay_setup_regs u_glay_setup_regs (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .setup_desc   (setup_desc),
        .setup_busy   (setup_busy),
        .setup_done   (setup_done)
    );

    glay_kernel_setup u_glay_kernel_setup (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .setup_desc   (setup_desc),
        .setup_busy   (setup_busy),
        .setup_done   (setup_done),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready)
    );

endmodule : glay_setup_top

`default_nettype wire

//--- testbench/glay_setup_assert.sv
`timescale 1ns/10ps
`default_nettype none

module glay_setup_assert import glay_setup_pkg::*; (
    input logic     ap_clk,
    input logic     setup_areset,
    input logic     req_valid,
    input mem_req_t req,
    input logic     req_ready,
    input logic     setup_done,
    input logic     fifo_full,
    input logic     fifo_wr_en
);

    // Stalled request keeps valid and payload
    a_req_stable: assert property (
        @(posedge ap_clk) disable iff (setup_areset)
        (req_valid && !req_ready) |=> (req_valid && $stable(req))
    ) else $error("memory request changed while stalled");

    // Done only once the stream has drained, and for one cycle
    a_done_pulse: assert property (
        @(posedge ap_clk) disable iff (setup_areset)
        setup_done |-> (!req_valid ##1 !setup_done)
    ) else $error("setup_done held too long or raised with requests pending");

    // Engine pauses early enough to never overflow
    a_no_overflow: assert property (
        @(posedge ap_clk) disable iff (setup_areset)
        fifo_full |-> !fifo_wr_en
    ) else $error("request FIFO written while full");

endmodule : glay_setup_assert

bind glay_kernel_setup glay_setup_assert u_glay_setup_assert (
    .ap_clk       (ap_clk),
    .setup_areset (setup_areset),
    .req_valid    (req_valid),
    .req          (req),
    .req_ready    (req_ready),
    .setup_done   (setup_done),
    .fifo_full    (fifo_full),
    .fifo_wr_en   (engine_req_valid)
);

`default_nettype wire

//--- testbench/glay_setup_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "glay_setup_cfg.svh"

module glay_setup_tb import glay_setup_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int AXIL_LIMIT   = 50;
    localparam int POLL_LIMIT   = 2000;

    logic      ap_clk;
    logic      setup_areset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      req_valid;
    mem_req_t  req;
    logic      req_ready;

    // Test table from the stimulus file
    logic [63:0] tst_addr [$];
    logic [15:0] tst_lines [$];
    logic [15:0] tst_stride [$];
    logic [31:0] tst_status [$];
    int          busy_idx;

    mem_req_t    expected_q [$];
    logic        random_ready;
    logic [31:0] lcg_state;
    int          rx_total;
    int          budget_cycles;
    logic        budget_ready;
    int          fail_count;
    logic        pass_printed;
    string       test_name;

    glay_setup_top u_glay_setup_top (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready)
    );

    initial begin
        ap_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
        end
    end

// ----------------------------------------------------------------------
//   Reporting
// ----------------------------------------------------------------------
    task automatic stop_on_failure();
        fail_count++;
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        stop_on_failure();
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %0h actual %0h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

// ----------------------------------------------------------------------
//   AXI4-Lite host
// ----------------------------------------------------------------------
    // Select 0 awready, 1 bvalid, 2 arready, else rvalid
    task automatic wait_rsp(input int sel, input string what);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            case (sel)
                0:       seen = axil_rsp.awready;
                1:       seen = axil_rsp.bvalid;
                2:       seen = axil_rsp.arready;
                default: seen = axil_rsp.rvalid;
            endcase
            if (!seen) begin
                if (waited == AXIL_LIMIT) begin
                    abort_run({"no ", what, " from the register block"});
                end
                waited++;
                @(negedge ap_clk);
            end
        end
    endtask

    task automatic axil_write(input logic [5:0] addr, input logic [31:0] data);
        @(negedge ap_clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.bready  = 1'b1;
        wait_rsp(0, "write ready");
        check({test_name, " wready"}, 64'd1, 64'(axil_rsp.wready));
        @(negedge ap_clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        wait_rsp(1, "write response");
        check({test_name, " bresp"}, 64'd0, 64'(axil_rsp.bresp));
        @(negedge ap_clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [5:0] addr, output logic [31:0] data);
        @(negedge ap_clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        wait_rsp(2, "read address ready");
        @(negedge ap_clk);
        axil_req.arvalid = 1'b0;
        wait_rsp(3, "read data");
        check({test_name, " rresp"}, 64'd0, 64'(axil_rsp.rresp));
        data = axil_rsp.rdata;
        @(negedge ap_clk);
        axil_req.rready = 1'b0;
    endtask

// ----------------------------------------------------------------------
//   Test steps
// ----------------------------------------------------------------------
    task automatic load_tests();
        int          fd;
        string       line;
        logic [63:0] a;
        logic [15:0] n;
        logic [15:0] s;
        logic [31:0] st;
        fd = $fopen("testbench/glay_setup_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open testbench/glay_setup_stim.txt");
        end
        budget_cycles = RESET_CYCLES + 500;
        busy_idx      = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "#"
                && $sscanf(line, "%h %h %h %h", a, n, s, st) == 4) begin
                tst_addr.push_back(a);
                tst_lines.push_back(n);
                tst_stride.push_back(s);
                tst_status.push_back(st);
                // Each line runs twice, ready high then random ready
                budget_cycles += 2 * (int'(n) + 20) * 4;
                if (n > tst_lines[busy_idx]) begin
                    busy_idx = tst_addr.size() - 1;
                end
            end
        end
        $fclose(fd);
        if (tst_addr.size() == 0) begin
            abort_run("stimulus file holds no tests");
        end
        budget_cycles += (int'(tst_lines[busy_idx]) + 20) * 4;
        budget_ready = 1'b1;
    endtask

    task automatic program_desc(input logic [63:0] addr, input logic [15:0] lines,
                                input logic [15:0] stride);
        logic [31:0] rd;
        axil_write(`GLAY_REG_ADDR_LO, addr[31:0]);
        axil_write(`GLAY_REG_ADDR_HI, addr[63:32]);
        axil_write(`GLAY_REG_LINES, {16'h0, lines});
        axil_write(`GLAY_REG_STRIDE, {16'h0, stride});
        axil_read(`GLAY_REG_ADDR_LO, rd);
        check({test_name, " addr_lo"}, 64'(addr[31:0]), 64'(rd));
        axil_read(`GLAY_REG_ADDR_HI, rd);
        check({test_name, " addr_hi"}, 64'(addr[63:32]), 64'(rd));
        axil_read(`GLAY_REG_LINES, rd);
        check({test_name, " lines"}, 64'(lines), 64'(rd));
        axil_read(`GLAY_REG_STRIDE, rd);
        check({test_name, " stride"}, 64'(stride), 64'(rd));
    endtask

    // Request k reads line array_pointer + k * stride * line size
    task automatic expect_requests(input logic [63:0] base, input logic [15:0] lines,
                                   input logic [15:0] stride);
        mem_req_t r;
        int       k;
        for (k = 0; k < int'(lines); k++) begin
            r.address = base + 64'(k) * 64'(stride) * 64'(`GLAY_LINE_BYTES);
            r.id      = 16'(k);
            expected_q.push_back(r);
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        int polls;
        polls  = 0;
        status = 32'h0;
        while (status[1] == 1'b0) begin
            axil_read(`GLAY_REG_STATUS, status);
            polls++;
            if (polls > POLL_LIMIT) begin
                abort_run({test_name, " never reported done"});
            end
        end
    endtask

    task automatic run_test(input int idx, input logic random_mode);
        logic [31:0] status;
        int          start_total;
        test_name    = $sformatf("test %0d %s", idx, random_mode ? "random ready" : "ready high");
        random_ready = random_mode;
        program_desc(tst_addr[idx], tst_lines[idx], tst_stride[idx]);
        expect_requests(tst_addr[idx], tst_lines[idx], tst_stride[idx]);
        start_total = rx_total;
        axil_write(`GLAY_REG_CTRL, 32'h1);
        if (tst_lines[idx] != 16'h0) begin
            axil_read(`GLAY_REG_STATUS, status);
            check({test_name, " busy status"}, 64'h1, 64'(status));
        end
        wait_done(status);
        check({test_name, " final status"}, 64'(tst_status[idx]), 64'(status));
        check({test_name, " request count"}, 64'(tst_lines[idx]), 64'(rx_total - start_total));
        check({test_name, " requests left"}, 64'd0, 64'(expected_q.size()));
    endtask

    // Second start and a new line count arrive mid run and must be dropped
    task automatic run_busy_test(input int idx);
        logic [31:0] status;
        int          start_total;
        test_name    = "start while busy";
        random_ready = 1'b1;
        program_desc(tst_addr[idx], tst_lines[idx], tst_stride[idx]);
        expect_requests(tst_addr[idx], tst_lines[idx], tst_stride[idx]);
        start_total = rx_total;
        axil_write(`GLAY_REG_CTRL, 32'h1);
        axil_write(`GLAY_REG_LINES, {16'h0, tst_lines[idx] + 16'd5});
        axil_write(`GLAY_REG_CTRL, 32'h1);
        axil_read(`GLAY_REG_STATUS, status);
        check({test_name, " busy status"}, 64'h1, 64'(status));
        wait_done(status);
        repeat (20) @(negedge ap_clk);
        axil_read(`GLAY_REG_STATUS, status);
        check({test_name, " final status"}, 64'(tst_status[idx]), 64'(status));
        check({test_name, " request count"}, 64'(tst_lines[idx]), 64'(rx_total - start_total));
        check({test_name, " requests left"}, 64'd0, 64'(expected_q.size()));
    endtask

// ----------------------------------------------------------------------
//   Main sequence
// ----------------------------------------------------------------------
    initial begin
        logic [31:0] status;
        axil_req     = '0;
        setup_areset = 1'b1;
        random_ready = 1'b0;
        budget_ready = 1'b0;
        fail_count   = 0;
        pass_printed = 1'b0;
        test_name    = "reset";
        load_tests();
        repeat (RESET_CYCLES) @(negedge ap_clk);
        setup_areset = 1'b0;
        @(negedge ap_clk);
        check("reset req_valid", 64'd0, 64'(req_valid));
        axil_read(`GLAY_REG_STATUS, status);
        check("reset status", 64'd0, 64'(status));
        for (int i = 0; i < tst_addr.size(); i++) begin
            run_test(i, 1'b0);
            run_test(i, 1'b1);
        end
        run_busy_test(busy_idx);
        if (fail_count == 0) begin
            pass_printed = 1'b1;
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

    // req_ready driver and request monitor in one process
    initial begin
        mem_req_t held;
        mem_req_t exp_req;
        logic     stalled;
        logic     ready_now;
        lcg_state = 32'd79380;
        req_ready = 1'b0;
        rx_total  = 0;
        stalled   = 1'b0;
        forever begin
            @(negedge ap_clk);
            if (setup_areset) begin
                ready_now = 1'b0;
            end else if (random_ready) begin
                ready_now = ((lcg_next() >> 16) % 32'd8) < 32'd3;
            end else begin
                ready_now = 1'b1;
            end
            req_ready = ready_now;
            if (stalled) begin
                check({test_name, " stall valid"}, 64'd1, 64'(req_valid));
                check({test_name, " stall address"}, held.address, req.address);
                check({test_name, " stall id"}, 64'(held.id), 64'(req.id));
            end
            if (req_valid && ready_now) begin
                if (expected_q.size() == 0) begin
                    abort_run({test_name, " sent a request that was not expected"});
                end
                exp_req = expected_q.pop_front();
                check({test_name, " address"}, exp_req.address, req.address);
                check({test_name, " id"}, 64'(exp_req.id), 64'(req.id));
                rx_total++;
            end
            stalled = req_valid && !ready_now;
            held    = req;
        end
    end

    initial begin
        wait (budget_ready);
        repeat (budget_cycles) @(posedge ap_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", budget_cycles);
        stop_on_failure();
    end

    // Run cut short by a bound assertion
    final begin
        if (!pass_printed && fail_count == 0) begin
            $display("TESTS FAILED");
        end
    end

endmodule : glay_setup_tb

`default_nettype wire

//--- glay_setup_top.f
+incdir+src
src/glay_setup_pkg.sv
src/glay_req_fifo.sv
src/glay_serial_read_engine.sv
src/glay_setup_regs.sv
src/glay_kernel_setup.sv
src/glay_setup_top.sv
testbench/glay_setup_assert.sv
testbench/glay_setup_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := glay_setup_tb
FILELIST  := glay_setup_top.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)
STIM    := testbench/glay_setup_stim.txt

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(STIM)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "^TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/glay_setup_stim.txt
# array_pointer    num_lines stride expected_status    (all fields hex)
# expected_status is the STATUS word once a run ends, done set and busy clear
0000000000001000 0001 0001 2
0000000080000000 0010 0001 2
0000000000000000 0000 0001 2
00000000deadbe00 0003 0000 2
0000000100000040 0028 0002 2
00000000fffffc00 0005 0010 2
0000000000400000 0040 0001 2
ffffffffffffffc0 0002 0001 2
0000002000000000 0014 ffff 2
00000000000a0000 0007 0100 2
0000000012345600 0064 0003 2
0000000000002000 0021 0001 2
0000000000000040 0000 0000 2
00000000c0000000 0008 0040 2
0000004000000000 0030 0002 2
